// File: hdl/cpu_params_pkg.sv
`default_nettype none

package cpu_params_pkg;

    localparam int XLEN          = 32;
    localparam int ARF_DEPTH     = 32;   // x0 reads zero
    localparam int PRF_DEPTH     = 64;
    localparam int ARF_IDX       = $clog2(ARF_DEPTH);
    localparam int PRF_IDX       = $clog2(PRF_DEPTH);

    // Default queue depths
    localparam int ROB_DEPTH_DEF = 16;
    localparam int RS_DEPTH_DEF  = 8;

endpackage

`default_nettype wire

// File: hdl/uop_types_pkg.sv
`default_nettype none

package uop_types_pkg;
    import cpu_params_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7   // Signed compare
    } alu_op_t;

    typedef logic [ARF_IDX-1:0] arch_reg_t;
    typedef logic [PRF_IDX-1:0] phy_reg_t;
    typedef logic [XLEN-1:0]    data_t;

    // Decoded integer micro-op as it leaves the front end
    typedef struct packed {
        alu_op_t   op;
        logic      use_imm;   // imm replaces rs2
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        data_t     imm;
    } uop_t;

endpackage

`default_nettype wire

// File: hdl/backend_itfs.sv
`default_nettype none

interface rename_rob_itf
import cpu_params_pkg::*, uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
);
    logic                         alloc;
    arch_reg_t                    rd_arch;
    phy_reg_t                     rd_phy;    // 0 when nothing was allocated
    phy_reg_t                     old_phy;
    logic                         full;
    logic [$clog2(ROB_DEPTH)-1:0] rob_id;

    modport rename (output alloc, rd_arch, rd_phy, old_phy, input full, rob_id);
    modport rob    (input alloc, rd_arch, rd_phy, old_phy, output full, rob_id);
endinterface

interface rename_rs_itf
import cpu_params_pkg::*, uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
);
    logic                         dispatch;
    alu_op_t                      op;
    logic                         use_imm;
    data_t                        imm;
    phy_reg_t                     rs1_phy;
    logic                         rs1_ready;
    phy_reg_t                     rs2_phy;
    logic                         rs2_ready;
    phy_reg_t                     rd_phy;
    arch_reg_t                    rd_arch;
    logic [$clog2(ROB_DEPTH)-1:0] rob_id;
    logic                         full;

    modport rename (
        output dispatch, op, use_imm, imm, rs1_phy, rs1_ready, rs2_phy, rs2_ready,
        output rd_phy, rd_arch, rob_id,
        input  full
    );
    modport rs (
        input  dispatch, op, use_imm, imm, rs1_phy, rs1_ready, rs2_phy, rs2_ready,
        input  rd_phy, rd_arch, rob_id,
        output full
    );
endinterface

interface cdb_itf
import cpu_params_pkg::*, uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
);
    logic                         valid;
    logic [$clog2(ROB_DEPTH)-1:0] rob_id;
    phy_reg_t                     rd_phy;
    arch_reg_t                    rd_arch;
    data_t                        value;

    modport driver   (output valid, rob_id, rd_phy, rd_arch, value);
    modport listener (input valid, rob_id, rd_phy, rd_arch, value);
endinterface

interface rs_prf_itf
import uop_types_pkg::*;
;
    phy_reg_t rs1_phy;
    phy_reg_t rs2_phy;
    data_t    rs1_value;
    data_t    rs2_value;

    modport rs  (output rs1_phy, rs2_phy, input rs1_value, rs2_value);
    modport prf (input rs1_phy, rs2_phy, output rs1_value, rs2_value);
endinterface

`default_nettype wire

// File: hdl/rename_stage.sv
`default_nettype none

module rename_stage
import cpu_params_pkg::*;
import uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
)(
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic                 inst_valid_i,
    input  uop_t                 inst_uop_i,
    output logic                 inst_ready_o,

    input  logic                 commit_free_valid_i,
    input  phy_reg_t             commit_free_phy_i,

    rename_rob_itf.rename        to_rob,
    rename_rs_itf.rename         to_rs,
    cdb_itf.listener             cdb
);
    localparam int FL_DEPTH = PRF_DEPTH - ARF_DEPTH;
    localparam int FL_IDX   = $clog2(FL_DEPTH);

    phy_reg_t                     rat[ARF_DEPTH];
    logic [PRF_DEPTH-1:0]         busy;
    phy_reg_t                     fl_mem[FL_DEPTH];
    logic [FL_IDX-1:0]            fl_head;
    logic [FL_IDX-1:0]            fl_tail;
    logic [FL_IDX:0]              fl_cnt;

    logic                         accept;
    logic                         pop;
    phy_reg_t                     new_phy;
    phy_reg_t                     rs1_phy;
    phy_reg_t                     rs2_phy;
    logic [$clog2(ROB_DEPTH)-1:0] alloc_rob_id;

    assign inst_ready_o = (fl_cnt != '0) && !to_rob.full && !to_rs.full;
    assign accept       = inst_valid_i && inst_ready_o;
    assign pop          = accept && (inst_uop_i.rd != '0);   // x0 takes no register
    assign new_phy      = (inst_uop_i.rd != '0) ? fl_mem[fl_head] : '0;
    assign rs1_phy      = rat[inst_uop_i.rs1];
    assign rs2_phy      = rat[inst_uop_i.rs2];
    assign alloc_rob_id = to_rob.rob_id;

    assign to_rob.alloc   = accept;
    assign to_rob.rd_arch = inst_uop_i.rd;
    assign to_rob.rd_phy  = new_phy;
    assign to_rob.old_phy = rat[inst_uop_i.rd];

    assign to_rs.dispatch = accept;
    assign to_rs.op       = inst_uop_i.op;
    assign to_rs.use_imm  = inst_uop_i.use_imm;
    assign to_rs.imm      = inst_uop_i.imm;
    assign to_rs.rs1_phy  = rs1_phy;
    assign to_rs.rs2_phy  = rs2_phy;
    assign to_rs.rd_phy   = new_phy;
    assign to_rs.rd_arch  = inst_uop_i.rd;
    assign to_rs.rob_id   = alloc_rob_id;

    // A tag on the CDB this cycle already counts as ready
    assign to_rs.rs1_ready = !busy[rs1_phy] || (cdb.valid && cdb.rd_phy == rs1_phy);
    assign to_rs.rs2_ready = inst_uop_i.use_imm || !busy[rs2_phy]
                             || (cdb.valid && cdb.rd_phy == rs2_phy);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARF_DEPTH; i++)
                rat[i] <= phy_reg_t'(i);   // Identity map
            busy <= '0;
        end else begin
            if (cdb.valid && cdb.rd_arch != '0)
                busy[cdb.rd_phy] <= 1'b0;
            if (pop) begin
                rat[inst_uop_i.rd] <= new_phy;
                busy[new_phy]      <= 1'b1;
            end
        end
    end

    // Circular free list popped at rename and refilled at commit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FL_DEPTH; i++)
                fl_mem[i] <= phy_reg_t'(ARF_DEPTH + i);
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= (FL_IDX+1)'(FL_DEPTH);
        end else begin
            if (commit_free_valid_i) begin
                fl_mem[fl_tail] <= commit_free_phy_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            if (pop)
                fl_head <= fl_head + 1'b1;
            fl_cnt <= fl_cnt + (FL_IDX+1)'(commit_free_valid_i) - (FL_IDX+1)'(pop);
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob.sv
`default_nettype none

module rob
import cpu_params_pkg::*;
import uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF   // Power of two
)(
    input  logic                 clk,
    input  logic                 rst_n_i,

    output logic                 commit_valid_o,
    output arch_reg_t            commit_rd_o,
    output data_t                commit_value_o,
    output logic                 commit_free_valid_o,
    output phy_reg_t             commit_free_phy_o,

    rename_rob_itf.rob           from_rename,
    cdb_itf.listener             cdb
);
    localparam int ROB_IDX = $clog2(ROB_DEPTH);

    arch_reg_t            rd_arch_q[ROB_DEPTH];
    phy_reg_t             old_phy_q[ROB_DEPTH];
    logic                 release_q[ROB_DEPTH];
    data_t                value_q[ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    logic [ROB_IDX-1:0]   head;
    logic [ROB_IDX-1:0]   tail;
    logic [ROB_IDX:0]     count;
    logic                 alloc;

    assign from_rename.full   = (count == (ROB_IDX+1)'(ROB_DEPTH));
    assign from_rename.rob_id = tail;
    assign alloc              = from_rename.alloc && !from_rename.full;

    // Head retires as soon as it is done
    assign commit_valid_o      = (count != '0) && done_q[head];
    assign commit_rd_o         = rd_arch_q[head];
    assign commit_value_o      = value_q[head];
    assign commit_free_valid_o = commit_valid_o && release_q[head];
    assign commit_free_phy_o   = old_phy_q[head];

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_arch_q[tail] <= from_rename.rd_arch;
            old_phy_q[tail] <= from_rename.old_phy;
            release_q[tail] <= (from_rename.rd_phy != '0);
        end
        if (cdb.valid)
            value_q[cdb.rob_id] <= cdb.value;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (alloc) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (cdb.valid)
                done_q[cdb.rob_id] <= 1'b1;
            if (commit_valid_o)
                head <= head + 1'b1;
            count <= count + (ROB_IDX+1)'(alloc) - (ROB_IDX+1)'(commit_valid_o);
        end
    end

endmodule

`default_nettype wire

// File: hdl/int_rs.sv
`default_nettype none

module int_rs
import cpu_params_pkg::*;
import uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF,
    parameter int RS_DEPTH  = RS_DEPTH_DEF
)(
    input  logic                 clk,
    input  logic                 rst_n_i,

    rename_rs_itf.rs             from_rename,
    rs_prf_itf.rs                to_prf,
    cdb_itf.driver               cdb        // Also read back for wakeup
);
    localparam int ROB_IDX = $clog2(ROB_DEPTH);
    localparam int RS_IDX  = $clog2(RS_DEPTH);
    localparam int SH_W    = $clog2(XLEN);

    logic [RS_DEPTH-1:0]  valid;
    logic [RS_IDX-1:0]    age[RS_DEPTH];   // Number of younger valid entries
    logic [RS_DEPTH-1:0]  rs1_rdy;
    logic [RS_DEPTH-1:0]  rs2_rdy;
    alu_op_t              op_q[RS_DEPTH];
    logic                 use_imm_q[RS_DEPTH];
    data_t                imm_q[RS_DEPTH];
    phy_reg_t             rs1_phy_q[RS_DEPTH];
    phy_reg_t             rs2_phy_q[RS_DEPTH];
    phy_reg_t             rd_phy_q[RS_DEPTH];
    arch_reg_t            rd_arch_q[RS_DEPTH];
    logic [ROB_IDX-1:0]   rob_id_q[RS_DEPTH];

    logic                 dispatch;
    logic [RS_IDX-1:0]    free_idx;
    logic                 issue;
    logic [RS_IDX-1:0]    sel;
    data_t                opa;
    data_t                opb;
    data_t                result;

    assign from_rename.full = &valid;
    assign dispatch         = from_rename.dispatch && !from_rename.full;

    // Lowest empty slot
    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
            if (!valid[i])
                free_idx = RS_IDX'(i);
    end

    // Oldest entry with both operands ready
    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && rs1_rdy[i] && rs2_rdy[i] && (!issue || age[i] > age[sel])) begin
                issue = 1'b1;
                sel   = RS_IDX'(i);
            end
        end
    end

    assign to_prf.rs1_phy = rs1_phy_q[sel];
    assign to_prf.rs2_phy = rs2_phy_q[sel];
    assign opa            = to_prf.rs1_value;
    assign opb            = use_imm_q[sel] ? imm_q[sel] : to_prf.rs2_value;

    always_comb begin
        unique case (op_q[sel])
            ALU_ADD: result = opa + opb;
            ALU_SUB: result = opa - opb;
            ALU_AND: result = opa & opb;
            ALU_OR:  result = opa | opb;
            ALU_XOR: result = opa ^ opb;
            ALU_SLL: result = opa << opb[SH_W-1:0];
            ALU_SRL: result = opa >> opb[SH_W-1:0];
            ALU_SLT: result = data_t'($signed(opa) < $signed(opb));
        endcase
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            op_q[free_idx]      <= from_rename.op;
            use_imm_q[free_idx] <= from_rename.use_imm;
            imm_q[free_idx]     <= from_rename.imm;
            rs1_phy_q[free_idx] <= from_rename.rs1_phy;
            rs2_phy_q[free_idx] <= from_rename.rs2_phy;
            rd_phy_q[free_idx]  <= from_rename.rd_phy;
            rd_arch_q[free_idx] <= from_rename.rd_arch;
            rob_id_q[free_idx]  <= from_rename.rob_id;
        end
        if (issue) begin   // ALU output register feeds the CDB
            cdb.rob_id  <= rob_id_q[sel];
            cdb.rd_phy  <= rd_phy_q[sel];
            cdb.rd_arch <= rd_arch_q[sel];
            cdb.value   <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid     <= '0;
            rs1_rdy   <= '0;
            rs2_rdy   <= '0;
            cdb.valid <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++)
                age[i] <= '0;
        end else begin
            cdb.valid <= issue;
            for (int i = 0; i < RS_DEPTH; i++) begin
                // Older entries lose the issued one from their younger count
                age[i] <= age[i] + RS_IDX'(dispatch) - RS_IDX'(issue && age[i] > age[sel]);
                if (cdb.valid && cdb.rd_phy == rs1_phy_q[i])
                    rs1_rdy[i] <= 1'b1;
                if (cdb.valid && cdb.rd_phy == rs2_phy_q[i])
                    rs2_rdy[i] <= 1'b1;
            end
            if (issue)
                valid[sel] <= 1'b0;
            if (dispatch) begin
                valid[free_idx]   <= 1'b1;
                age[free_idx]     <= '0;
                rs1_rdy[free_idx] <= from_rename.rs1_ready;
                rs2_rdy[free_idx] <= from_rename.rs2_ready;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/prf.sv
`default_nettype none

module prf
import cpu_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,

    rs_prf_itf.prf               from_rs,
    cdb_itf.listener             cdb
);
    data_t regs[PRF_DEPTH];

    // Asynchronous read
    assign from_rs.rs1_value = regs[from_rs.rs1_phy];
    assign from_rs.rs2_value = regs[from_rs.rs2_phy];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PRF_DEPTH; i++)
                regs[i] <= '0;
        end else if (cdb.valid && cdb.rd_phy != '0) begin   // p0 stays zero
            regs[cdb.rd_phy] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/backend_top.sv
`default_nettype none

module backend_top
import cpu_params_pkg::*;
import uop_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF,
    parameter int RS_DEPTH  = RS_DEPTH_DEF
)(
    input  logic                 clk,
    input  logic                 rst_n_i,

    input  logic                 inst_valid_i,
    input  uop_t                 inst_uop_i,
    output logic                 inst_ready_o,

    output logic                 commit_valid_o,
    output arch_reg_t            commit_rd_o,
    output data_t                commit_value_o
);
    rename_rob_itf #(.ROB_DEPTH(ROB_DEPTH)) rename_rob_itf_i();
    rename_rs_itf  #(.ROB_DEPTH(ROB_DEPTH)) rename_rs_itf_i();
    cdb_itf        #(.ROB_DEPTH(ROB_DEPTH)) cdb_itf_i();
    rs_prf_itf                              rs_prf_itf_i();

    // Register release from commit back to the free list
    logic                       commit_free_valid;
    phy_reg_t                   commit_free_phy;

    rename_stage #(
        .ROB_DEPTH              (ROB_DEPTH)
    ) rename_stage_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .inst_valid_i           (inst_valid_i),
        .inst_uop_i             (inst_uop_i),
        .inst_ready_o           (inst_ready_o),
        .commit_free_valid_i    (commit_free_valid),
        .commit_free_phy_i      (commit_free_phy),
        .to_rob                 (rename_rob_itf_i),
        .to_rs                  (rename_rs_itf_i),
        .cdb                    (cdb_itf_i)
    );

    rob #(
        .ROB_DEPTH              (ROB_DEPTH)
    ) rob_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .commit_valid_o         (commit_valid_o),
        .commit_rd_o            (commit_rd_o),
        .commit_value_o         (commit_value_o),
        .commit_free_valid_o    (commit_free_valid),
        .commit_free_phy_o      (commit_free_phy),
        .from_rename            (rename_rob_itf_i),
        .cdb                    (cdb_itf_i)
    );

    int_rs #(
        .ROB_DEPTH              (ROB_DEPTH),
        .RS_DEPTH               (RS_DEPTH)
    ) int_rs_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .from_rename            (rename_rs_itf_i),
        .to_prf                 (rs_prf_itf_i),
        .cdb                    (cdb_itf_i)
    );

    prf prf_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .from_rs                (rs_prf_itf_i),
        .cdb                    (cdb_itf_i)
    );

endmodule

`default_nettype wire

// File: sim/backend_tb.sv
`default_nettype none

module backend_tb
import cpu_params_pkg::*;
import uop_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_DEPTH    = ROB_DEPTH_DEF;
    localparam int RS_DEPTH     = RS_DEPTH_DEF;
    localparam int SEED         = 41166;
    localparam int ALU_OPS      = 2 * 18;
    localparam int CHAIN_OPS    = 17;
    localparam int X0_OPS       = 5;
    localparam int BURST_LEN    = ROB_DEPTH + 8;
    localparam int RANDOM_OPS   = 300;
    localparam int TOTAL_OPS    = ALU_OPS + CHAIN_OPS + X0_OPS + BURST_LEN + 1 + RANDOM_OPS;
    localparam int MAX_CYCLES   = 40 * TOTAL_OPS + 200;
    localparam int DRAIN_CYCLES = 40 * ROB_DEPTH;

    logic      clk;
    logic      rst_n_i;
    logic      inst_valid_i;
    uop_t      inst_uop_i;
    logic      inst_ready_o;
    logic      commit_valid_o;
    arch_reg_t commit_rd_o;
    data_t     commit_value_o;

    data_t     arch_regs[ARF_DEPTH];   // Reference register state
    arch_reg_t exp_rd_q[$];
    data_t     exp_value_q[$];
    int        value_errors = 0;
    int        protocol_errors = 0;
    int        cycle_cnt = 0;
    int        issued_ops = 0;
    logic      stall_seen;

    backend_top #(
        .ROB_DEPTH      (ROB_DEPTH),
        .RS_DEPTH       (RS_DEPTH)
    ) backend_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_uop_i     (inst_uop_i),
        .inst_ready_o   (inst_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d commits outstanding",
                     cycle_cnt, exp_rd_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    // Operation rules of the integer ALU
    function automatic data_t alu_ref(alu_op_t op, data_t a, data_t b);
        data_t r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic uop_t build_uop(alu_op_t op, logic use_imm, int rd, int rs1, int rs2,
                                       data_t imm);
        uop_t u;
        u.op      = op;
        u.use_imm = use_imm;
        u.rd      = arch_reg_t'(rd);
        u.rs1     = arch_reg_t'(rs1);
        u.rs2     = arch_reg_t'(rs2);
        u.imm     = imm;
        return u;
    endfunction

    task automatic check_rd(string name, arch_reg_t exp, arch_reg_t got);
        if (exp !== got) begin
            value_errors++;
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t got);
        if (exp !== got) begin
            value_errors++;
            $display("ERR t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (exp !== got) begin
            value_errors++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_commit();
        arch_reg_t rd;
        data_t     value;
        rd    = exp_rd_q.pop_front();
        value = exp_value_q.pop_front();
        check_rd("commit_rd_o", rd, commit_rd_o);
        check_data("commit_value_o", value, commit_value_o);
    endtask

    task automatic check_idle(logic commit_seen);
        if (commit_seen) begin
            protocol_errors++;
            $display("Commit of rd %0d at %0t arrived with no op outstanding",
                     commit_rd_o, $time);
        end else if (exp_rd_q.size() != 0) begin
            protocol_errors++;
            $display("%0d accepted ops never committed", exp_rd_q.size());
        end
    endtask

    // Commit outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            if (exp_rd_q.size() == 0)
                check_idle(1'b1);
            else
                check_commit();
        end
    end

    task automatic idle_cycles(int n);
        inst_valid_i = 1'b0;
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Holds the op until accepted, then updates the model in program order
    task automatic send_op(uop_t u);
        logic  accepted;
        data_t opb;
        data_t result;
        accepted     = 1'b0;
        inst_valid_i = 1'b1;
        inst_uop_i   = u;
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready_o;
            if (!accepted)
                stall_seen = 1'b1;
            @(posedge clk);
            #2;
        end
        inst_valid_i = 1'b0;
        opb    = u.use_imm ? u.imm : arch_regs[u.rs2];
        result = alu_ref(u.op, arch_regs[u.rs1], opb);
        exp_rd_q.push_back(u.rd);
        exp_value_q.push_back(result);
        if (u.rd != '0)
            arch_regs[u.rd] = result;
        issued_ops++;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("inst_ready_o", 1'b1, inst_ready_o);
        @(posedge clk);
        #2;
        idle_cycles(10);   // Any commit here is flagged by the monitor
    endtask

    task automatic test_alu_ops();
        data_t a_vals[2];
        data_t b_vals[2];
        data_t imm_vals[2];
        a_vals   = '{32'hF0F0_1234, 32'h0000_7A5C};
        b_vals   = '{32'h0000_0005, 32'hFFFF_FFF9};
        imm_vals = '{32'h8000_0003, 32'h0000_0010};
        for (int p = 0; p < 2; p++) begin
            send_op(build_uop(ALU_ADD, 1'b1, 1, 0, 0, a_vals[p]));
            send_op(build_uop(ALU_ADD, 1'b1, 2, 0, 0, b_vals[p]));
            for (int k = 0; k < 8; k++) begin
                send_op(build_uop(alu_op_t'(k), 1'b0, 3 + k, 1, 2, '0));
                send_op(build_uop(alu_op_t'(k), 1'b1, 11 + k, 1, 0, imm_vals[p]));
            end
            idle_cycles(4);
        end
    endtask

    task automatic test_chain();
        send_op(build_uop(ALU_ADD, 1'b1, 5, 0, 0, 32'd1));
        for (int i = 0; i < CHAIN_OPS - 1; i++) begin
            if (i % 4 == 3)
                send_op(build_uop(ALU_ADD, 1'b0, 5, 5, 5, '0));
            else
                send_op(build_uop(alu_op_t'(i % 8), 1'b1, 5, 5, 0,
                                  32'h0000_1000 * i + 32'h0000_0A53 + i));
        end
    endtask

    task automatic test_reg_zero();
        send_op(build_uop(ALU_ADD, 1'b1, 0, 0, 0, 32'h55));
        send_op(build_uop(ALU_ADD, 1'b1, 6, 0, 0, 32'd7));
        send_op(build_uop(ALU_OR, 1'b0, 7, 0, 0, '0));
        send_op(build_uop(ALU_ADD, 1'b0, 0, 6, 6, '0));
        send_op(build_uop(ALU_ADD, 1'b0, 8, 0, 6, '0));   // Must see 0 for x0
    endtask

    task automatic test_backpressure();
        stall_seen = 1'b0;
        send_op(build_uop(ALU_ADD, 1'b1, 9, 0, 0, 32'd3));
        for (int i = 0; i < BURST_LEN; i++) begin
            if (i % 3 == 0)
                send_op(build_uop(ALU_ADD, 1'b0, 9, 9, 9, '0));
            else
                send_op(build_uop(alu_op_t'(i % 8), 1'b1, 9, 9, 0, 32'h11 * i + 1));
        end
        if (!stall_seen) begin
            protocol_errors++;
            $display("inst_ready_o never went low during the dependent burst");
        end
    endtask

    task automatic test_random();
        uop_t u;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            u.op      = alu_op_t'($urandom_range(0, 7));
            u.use_imm = logic'($urandom_range(0, 1));
            u.rd      = arch_reg_t'($urandom_range(0, ARF_DEPTH - 1));
            u.rs1     = arch_reg_t'($urandom_range(0, ARF_DEPTH - 1));
            u.rs2     = arch_reg_t'($urandom_range(0, ARF_DEPTH - 1));
            u.imm     = $urandom;
            send_op(u);
            if ($urandom_range(0, 3) == 0)
                idle_cycles($urandom_range(1, 3));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_uop_i   = '0;
        stall_seen   = 1'b0;
        for (int i = 0; i < ARF_DEPTH; i++)
            arch_regs[i] = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        test_reset_state();
        test_alu_ops();
        test_chain();
        test_reg_zero();
        test_backpressure();
        test_random();

        // Outstanding commits get a bounded drain window
        for (int c = 0; c < DRAIN_CYCLES && exp_rd_q.size() != 0; c++)
            @(posedge clk);
        idle_cycles(10);
        check_idle(1'b0);

        $display("Issued %0d ops, %0d value errors, %0d protocol errors",
                 issued_ops, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: backend.f
hdl/cpu_params_pkg.sv
hdl/uop_types_pkg.sv
hdl/backend_itfs.sv
hdl/rename_stage.sv
hdl/rob.sv
hdl/int_rs.sv
hdl/prf.sv
hdl/backend_top.sv
sim/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module backend_tb \
    -f backend.f -o backend_sim > build.log 2>&1 \
    && ./obj_dir/backend_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^TB PASSED$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
